//--- list.f
+incdir+include
hw/alu_pkg.sv
hw/alu_result_if.sv
hw/operand_regs.sv
hw/alu.sv
hw/status_reg.sv
hw/alu_datapath.sv
tests/alu_datapath_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu_datapath_tb
LINT_TOP  ?= alu_datapath
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Result: PASSED
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/alu_datapath_tb.sv
`default_nettype none

`include "alu_config.svh"

module alu_datapath_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int CYCLES_PER_ROW = 50;
    localparam int RANDOM_ROWS    = 40;

    // one table row holds the stimulus and the values the model expects for it
    typedef struct packed {
        logic [`ALU_OP_W-1:0]   op;
        logic [`ALU_DATA_W-1:0] a;
        logic [`ALU_DATA_W-1:0] b;
        logic                   fpx;
        logic                   fxz;
        logic                   wb;
        logic [`ALU_REG_AW-1:0] x_reg;
        logic [`ALU_DATA_W-1:0] exp_result;
        logic                   exp_carry_n;
        logic                   exp_zero;
        logic                   exp_neg;
        logic                   exp_invalid;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   load_en;
    logic [`ALU_REG_AW-1:0] load_addr;
    logic [`ALU_DATA_W-1:0] load_data;
    logic                   exec;
    logic                   write_back;
    logic [`ALU_REG_AW-1:0] x_addr;
    logic [`ALU_REG_AW-1:0] y_addr;
    logic [`ALU_REG_AW-1:0] dest_addr;
    logic [`ALU_OP_W-1:0]   alu_op;
    logic                   force_pass_x;
    logic                   force_x_zero;
    logic [`ALU_DATA_W-1:0] result;
    logic                   carry_out_n;
    logic                   zero;
    logic                   negative;
    logic                   op_invalid;

    row_t rows[$];
    // model copy of the register file and of the stored active-low carry
    logic [`ALU_DATA_W-1:0] model_regs [`ALU_REG_COUNT];
    logic model_carry_n = 1'b1;
    int seed = 32'hc94e;
    int cycle_count = 0;
    int timeout_limit = RESET_CYCLES + CYCLES_PER_ROW;

    alu_datapath i_dut (.*);

    always #4 clk = ~clk;

    // the watchdog limit grows with the number of table rows
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout, the run did not finish within %0d cycles", timeout_limit);
            $display("Result: FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected 0x%02h actual 0x%02h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // reference model built from the opcode table and the carry rules
    task automatic model_op(input logic [4:0] op_raw, input logic [7:0] x, input logic [7:0] y,
                            input logic fpx, input logic fxz, input logic cin_n,
                            output logic [7:0] res, output logic cout_n, output logic inv);
        logic [4:0] eff;
        logic [7:0] a;
        logic arith;
        int t;
        int c;
        eff = fpx ? 5'd0 : op_raw;
        a = fxz ? 8'h00 : x;
        c = cin_n ? 0 : 1;
        // codes 3 to 15 take their carry from bit 8, except the unused code 12
        arith = (eff >= 5'd3) && (eff <= 5'd15) && (eff != 5'd12);
        t = 0;
        res = 8'hff;
        inv = 1'b0;
        case (alu_pkg::alu_op_e'(eff))
            alu_pkg::op_a:      res = a;
            alu_pkg::op_b:      res = y;
            alu_pkg::op_zero:   res = 8'h00;
            alu_pkg::op_neg_a:  t = -int'(a);
            alu_pkg::op_neg_b:  t = -int'(y);
            alu_pkg::op_a_inc:  t = int'(a) + 1;
            alu_pkg::op_b_inc:  t = int'(y) + 1;
            alu_pkg::op_a_dec:  t = int'(a) - 1;
            alu_pkg::op_b_dec:  t = int'(y) - 1;
            alu_pkg::op_add:    t = int'(a) + int'(y);
            alu_pkg::op_sub:    t = int'(a) - int'(y);
            alu_pkg::op_rsub:   t = int'(y) - int'(a);
            alu_pkg::op_add_c:  t = int'(a) + int'(y) + c;
            alu_pkg::op_sub_c:  t = int'(a) - int'(y) - c;
            alu_pkg::op_rsub_c: t = int'(y) - int'(a) - c;
            alu_pkg::op_mul_hi: t = (int'(a) * int'(y)) >> 8;
            alu_pkg::op_mul_lo: t = int'(a) * int'(y);
            // shifting a full int by 8 or more leaves 00 or the sign fill in the low byte
            alu_pkg::op_shl:    t = int'(a) << y;
            alu_pkg::op_sar:    t = int'($signed(a)) >>> y;
            alu_pkg::op_shr:    t = int'(a) >> y;
            alu_pkg::op_and:    res = a & y;
            alu_pkg::op_or:     res = a | y;
            alu_pkg::op_xor:    res = a ^ y;
            alu_pkg::op_not_a:  res = ~a;
            alu_pkg::op_not_b:  res = ~y;
            default:            inv = 1'b1;
        endcase
        if (!inv && (arith || (eff >= 5'd16 && eff <= 5'd22))) begin
            res = t[7:0];
        end
        cout_n = arith ? ~t[8] : 1'b1;
    endtask

    // runs the model over one row in table order, so the carry and write-back chain
    task automatic add_row(input logic [4:0] op, input logic [7:0] a, input logic [7:0] b,
                           input logic fpx, input logic fxz, input logic wb,
                           input logic [1:0] x_reg);
        row_t r;
        logic [7:0] res;
        logic cout_n;
        logic inv;
        model_regs[0] = a;
        model_regs[1] = b;
        model_op(op, model_regs[x_reg], model_regs[1], fpx, fxz, model_carry_n, res, cout_n, inv);
        model_carry_n = cout_n;
        if (wb) begin
            model_regs[2] = res;
        end
        r = '{op, a, b, fpx, fxz, wb, x_reg, res, cout_n, (res == 8'h00), res[7], inv};
        rows.push_back(r);
    endtask

    initial begin
        row_t r;
        logic [31:0] rnd;
        clk = 1'b0;
        rst_n = 1'b0;
        load_en = 1'b0;
        load_addr = 2'd0;
        load_data = 8'h00;
        exec = 1'b0;
        write_back = 1'b0;
        x_addr = 2'd0;
        y_addr = 2'd1;
        dest_addr = 2'd2;
        alu_op = 5'd0;
        force_pass_x = 1'b0;
        force_x_zero = 1'b0;
        foreach (model_regs[i]) begin
            model_regs[i] = 8'h00;
        end

        // pass, negate, increment, decrement and plain add and subtract
        add_row(alu_pkg::op_a,      8'h5a, 8'h33, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_b,      8'h5a, 8'h93, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_zero,   8'h5a, 8'h33, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_neg_a,  8'h01, 8'h00, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_neg_a,  8'h00, 8'h00, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_neg_b,  8'h00, 8'h80, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_a_inc,  8'hff, 8'h00, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_b_inc,  8'h00, 8'h7f, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_a_dec,  8'h00, 8'h00, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_b_dec,  8'h00, 8'h01, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_add,    8'h7f, 8'h01, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_sub,    8'h10, 8'h20, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_rsub,   8'h10, 8'h30, 0, 0, 0, 2'd0);
        // carry chaining through the status register
        add_row(alu_pkg::op_add,    8'hf0, 8'h20, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_add_c,  8'h01, 8'h02, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_sub,    8'h10, 8'h20, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_sub_c,  8'h50, 8'h10, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_rsub_c, 8'h10, 8'h50, 0, 0, 0, 2'd0);
        // multiply, shifts including large amounts, and logic ops
        add_row(alu_pkg::op_mul_hi, 8'hff, 8'hff, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_mul_lo, 8'h12, 8'h34, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_shl,    8'h81, 8'h08, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_sar,    8'h80, 8'h03, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_sar,    8'h80, 8'hc9, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_shr,    8'h80, 8'h07, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_shr,    8'hff, 8'h08, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_and,    8'h5a, 8'h0f, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_or,     8'h5a, 8'h0f, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_xor,    8'h5a, 8'h0f, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_not_a,  8'h5a, 8'h0f, 0, 0, 0, 2'd0);
        add_row(alu_pkg::op_not_b,  8'h5a, 8'h0f, 0, 0, 0, 2'd0);
        // overrides and invalid codes
        add_row(alu_pkg::op_add,    8'h55, 8'h11, 0, 1, 0, 2'd0);
        add_row(alu_pkg::op_xor,    8'h5a, 8'h5a, 1, 0, 0, 2'd0);
        add_row(alu_pkg::op_b,      8'h5a, 8'h33, 1, 1, 0, 2'd0);
        add_row(5'd18,              8'h12, 8'h34, 0, 0, 0, 2'd0);
        add_row(5'd24,              8'h12, 8'h34, 0, 0, 0, 2'd0);
        // write-back into register 2, then read it back as the x operand
        add_row(alu_pkg::op_add,    8'h12, 8'h34, 0, 0, 1, 2'd0);
        add_row(alu_pkg::op_add,    8'h00, 8'h10, 0, 0, 1, 2'd2);
        add_row(alu_pkg::op_shl,    8'h00, 8'h01, 0, 0, 0, 2'd2);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            rnd = $random(seed);
            add_row(rnd[4:0], rnd[12:5], rnd[20:13], rnd[23:21] == 3'd0, rnd[26:24] == 3'd0,
                    rnd[27], {rnd[28], 1'b0});
        end
        timeout_limit = RESET_CYCLES + CYCLES_PER_ROW * rows.size();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check("result", 8'h00, result);
        check("carry_out_n", 8'h01, 8'(carry_out_n));
        check("zero", 8'h00, 8'(zero));
        check("negative", 8'h00, 8'(negative));
        check("op_invalid", 8'h00, 8'(op_invalid));

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            @(posedge clk);
            #1;
            load_en = 1'b1;
            load_addr = 2'd0;
            load_data = r.a;
            @(posedge clk);
            #1;
            load_addr = 2'd1;
            load_data = r.b;
            @(posedge clk);
            #1;
            load_en = 1'b0;
            exec = 1'b1;
            x_addr = r.x_reg;
            alu_op = r.op;
            force_pass_x = r.fpx;
            force_x_zero = r.fxz;
            write_back = r.wb;
            // the status outputs move one edge after exec is sampled
            @(posedge clk);
            #1;
            exec = 1'b0;
            write_back = 1'b0;
            check("result", r.exp_result, result);
            check("carry_out_n", 8'(r.exp_carry_n), 8'(carry_out_n));
            check("zero", 8'(r.exp_zero), 8'(zero));
            check("negative", 8'(r.exp_neg), 8'(negative));
            check("op_invalid", 8'(r.exp_invalid), 8'(op_invalid));
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/alu_datapath.sv
`default_nettype none

`include "alu_config.svh"

// the arithmetic slice is made of the operand registers, the alu and the status register
module alu_datapath (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   load_en,
    input  wire logic [`ALU_REG_AW-1:0] load_addr,
    input  wire logic [`ALU_DATA_W-1:0] load_data,
    input  wire logic                   exec,
    input  wire logic                   write_back,
    input  wire logic [`ALU_REG_AW-1:0] x_addr,
    input  wire logic [`ALU_REG_AW-1:0] y_addr,
    input  wire logic [`ALU_REG_AW-1:0] dest_addr,
    input  wire logic [`ALU_OP_W-1:0]   alu_op,
    input  wire logic                   force_pass_x,
    input  wire logic                   force_x_zero,
    output logic      [`ALU_DATA_W-1:0] result,
    output logic                        carry_out_n,
    output logic                        zero,
    output logic                        negative,
    output logic                        op_invalid
);

    logic [`ALU_DATA_W-1:0] x;
    logic [`ALU_DATA_W-1:0] y;

    alu_result_if res_if ();

    // the write-back data is the live alu result, written on the exec edge
    operand_regs u_operand_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .exec       (exec),
        .write_back (write_back),
        .dest_addr  (dest_addr),
        .wb_data    (res_if.result),
        .x_addr     (x_addr),
        .y_addr     (y_addr),
        .x          (x),
        .y          (y)
    );

    alu u_alu (
        .x            (x),
        .y            (y),
        .alu_op       (alu_op),
        .force_pass_x (force_pass_x),
        .force_x_zero (force_x_zero),
        .res          (res_if.alu)
    );

    status_reg u_status_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .exec        (exec),
        .res         (res_if.status),
        .result      (result),
        .carry_out_n (carry_out_n),
        .zero        (zero),
        .negative    (negative),
        .op_invalid  (op_invalid)
    );

endmodule

`default_nettype wire

//--- hw/status_reg.sv
`default_nettype none

`include "alu_config.svh"

// holds the last alu result and its flags between exec strobes
module status_reg (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              exec,
    alu_result_if.status           res,
    output logic [`ALU_DATA_W-1:0] result,
    output logic                   carry_out_n,
    output logic                   zero,
    output logic                   negative,
    output logic                   op_invalid
);

    // reset gives the idle state with a zero result, no flags and the carry clear
    // carry is active low, so the idle value is 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result      <= '0;
            carry_out_n <= 1'b1;
            zero        <= 1'b0;
            negative    <= 1'b0;
            op_invalid  <= 1'b0;
        end else if (exec) begin
            result      <= res.result;
            carry_out_n <= res.carry_out_n;
            zero        <= (res.result == '0);
            negative    <= res.result[`ALU_DATA_W-1];
            op_invalid  <= res.op_invalid;
        end
    end

    // the stored carry goes back to the alu for the carry-chained ops
    assign res.carry_in_n = carry_out_n;

endmodule

`default_nettype wire

//--- hw/alu.sv
`default_nettype none

`include "alu_config.svh"

// combinational alu whose case follows the column layout of the 5-bit opcode map
module alu (
    input  wire logic [`ALU_DATA_W-1:0] x,
    input  wire logic [`ALU_DATA_W-1:0] y,
    input  wire logic [`ALU_OP_W-1:0]   alu_op,
    input  wire logic                   force_pass_x,
    input  wire logic                   force_x_zero,
    alu_result_if.alu                   res
);

    // operand a after the zero override, b is always y
    logic [`ALU_DATA_W-1:0] a;
    logic [`ALU_DATA_W-1:0] b;

    // 9-bit copies so that bit 8 of a sum or difference is the carry
    logic [`ALU_DATA_W:0] a9;
    logic [`ALU_DATA_W:0] b9;
    logic [`ALU_DATA_W:0] cin9;
    logic [`ALU_DATA_W:0] sum9;

    logic [2*`ALU_DATA_W-1:0] prod;
    logic [`ALU_DATA_W-1:0]   sign_fill;
    logic                     shift_big;
    logic [`ALU_DATA_W-1:0]   result_c;
    logic                     invalid_c;

    alu_pkg::alu_op_e op_eff;

    // force_x_zero takes the place of the pulled-down buffer on the x bus
    assign a = force_x_zero ? '0 : x;
    assign b = y;

    // force_pass_x takes the place of the opcode buffer, which reads back as op_a
    assign op_eff = force_pass_x ? alu_pkg::op_a : alu_pkg::alu_op_e'(alu_op);

    assign a9   = {1'b0, a};
    assign b9   = {1'b0, b};

    // the stored carry is active low, so a 0 here means add (or borrow) one
    assign cin9 = {{`ALU_DATA_W{1'b0}}, ~res.carry_in_n};

    assign prod = a * b;

    // shift distances past the width empty the byte, or fill it with the sign
    assign shift_big = (b >= `ALU_DATA_W);
    assign sign_fill = {`ALU_DATA_W{a[`ALU_DATA_W-1]}};

    always_comb begin
        sum9      = '0;
        result_c  = '1;
        invalid_c = 1'b0;
        case (op_eff)
            alu_pkg::op_a:      result_c = a;
            alu_pkg::op_b:      result_c = b;
            alu_pkg::op_zero:   result_c = '0;
            // arithmetic ops only build the 9-bit sum, the byte is taken below
            alu_pkg::op_neg_a:  sum9 = '0 - a9;
            alu_pkg::op_neg_b:  sum9 = '0 - b9;
            alu_pkg::op_a_inc:  sum9 = a9 + 1'b1;
            alu_pkg::op_b_inc:  sum9 = b9 + 1'b1;
            alu_pkg::op_a_dec:  sum9 = a9 - 1'b1;
            alu_pkg::op_b_dec:  sum9 = b9 - 1'b1;
            alu_pkg::op_add:    sum9 = a9 + b9;
            alu_pkg::op_sub:    sum9 = a9 - b9;
            alu_pkg::op_rsub:   sum9 = b9 - a9;
            alu_pkg::op_add_c:  sum9 = a9 + b9 + cin9;
            alu_pkg::op_sub_c:  sum9 = a9 - b9 - cin9;
            alu_pkg::op_rsub_c: sum9 = b9 - a9 - cin9;
            alu_pkg::op_mul_hi: result_c = prod[2*`ALU_DATA_W-1:`ALU_DATA_W];
            alu_pkg::op_mul_lo: result_c = prod[`ALU_DATA_W-1:0];
            alu_pkg::op_shl:    result_c = shift_big ? '0 : a << b;
            // both arms are signed so that >>> keeps the sign of a
            alu_pkg::op_sar:    result_c = shift_big ? $signed(sign_fill) : $signed(a) >>> b;
            alu_pkg::op_shr:    result_c = shift_big ? '0 : a >> b;
            alu_pkg::op_and:    result_c = a & b;
            alu_pkg::op_or:     result_c = a | b;
            alu_pkg::op_xor:    result_c = a ^ b;
            alu_pkg::op_not_a:  result_c = ~a;
            alu_pkg::op_not_b:  result_c = ~b;
            // rotate, divide, modulo, bcd and the special subtract land here too
            default: begin
                result_c  = '1;
                invalid_c = 1'b1;
            end
        endcase
        if (alu_pkg::op_has_carry(op_eff)) begin
            result_c = sum9[`ALU_DATA_W-1:0];
        end
    end

    assign res.result     = result_c;
    assign res.op_invalid = invalid_c;

    // only the add and subtract family drives a carry, everything else reads as clear
    assign res.carry_out_n = ~(alu_pkg::op_has_carry(op_eff) & sum9[`ALU_DATA_W]);

endmodule

`default_nettype wire

//--- hw/operand_regs.sv
`default_nettype none

`include "alu_config.svh"

// small register file that supplies the x and y operands of the alu
module operand_regs (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // external load port
    input  wire logic                   load_en,
    input  wire logic [`ALU_REG_AW-1:0] load_addr,
    input  wire logic [`ALU_DATA_W-1:0] load_data,

    // result write-back, qualified by exec
    input  wire logic                   exec,
    input  wire logic                   write_back,
    input  wire logic [`ALU_REG_AW-1:0] dest_addr,
    input  wire logic [`ALU_DATA_W-1:0] wb_data,

    // operand read ports
    input  wire logic [`ALU_REG_AW-1:0] x_addr,
    input  wire logic [`ALU_REG_AW-1:0] y_addr,
    output logic      [`ALU_DATA_W-1:0] x,
    output logic      [`ALU_DATA_W-1:0] y
);

    logic [`ALU_DATA_W-1:0] regs [`ALU_REG_COUNT];

    // a write-back only happens on the same strobe that updates the status register
    logic wb_en;

    assign wb_en = exec && write_back;

    // reset clears all four registers
    // an external load wins over a write-back in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `ALU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (load_en) begin
            regs[load_addr] <= load_data;
        end else if (wb_en) begin
            regs[dest_addr] <= wb_data;
        end
    end

    // both read ports are combinational
    // a value written at an edge shows up here in the following cycle
    assign x = regs[x_addr];
    assign y = regs[y_addr];

endmodule

`default_nettype wire

//--- hw/alu_result_if.sv
`default_nettype none

`include "alu_config.svh"

// link between the combinational alu and the status register
interface alu_result_if;

    // alu output byte
    logic [`ALU_DATA_W-1:0] result;

    // carry or borrow out, active low
    logic carry_out_n;

    // set when the effective opcode has no implementation
    logic op_invalid;

    // stored carry fed back from the status register, active low
    logic carry_in_n;

    // the alu produces the result and flags and consumes the stored carry
    modport alu (
        output result,
        output carry_out_n,
        output op_invalid,
        input  carry_in_n
    );

    // the status register samples the result and returns its stored carry
    modport status (
        input  result,
        input  carry_out_n,
        input  op_invalid,
        output carry_in_n
    );

endinterface

`default_nettype wire

//--- hw/alu_pkg.sv
`default_nettype none

`include "alu_config.svh"

package alu_pkg;

    // codes missing from this opcode map are invalid and give ff
    typedef enum logic [`ALU_OP_W-1:0] {
        op_a      = 5'd0,
        op_b      = 5'd1,
        op_zero   = 5'd2,
        op_neg_a  = 5'd3,
        op_neg_b  = 5'd4,
        op_a_inc  = 5'd5,
        op_b_inc  = 5'd6,
        op_a_dec  = 5'd7,
        op_b_dec  = 5'd8,
        op_add    = 5'd9,
        op_sub    = 5'd10,
        op_rsub   = 5'd11,
        op_add_c  = 5'd13,
        op_sub_c  = 5'd14,
        op_rsub_c = 5'd15,
        op_mul_hi = 5'd16,
        op_mul_lo = 5'd17,
        op_shl    = 5'd20,
        op_sar    = 5'd21,
        op_shr    = 5'd22,
        op_and    = 5'd25,
        op_or     = 5'd26,
        op_xor    = 5'd27,
        op_not_a  = 5'd28,
        op_not_b  = 5'd29
    } alu_op_e;

    // true for the add and subtract family whose carry is bit 8 of the sum
    // code 12 sits in that range but is not implemented, so it is not listed
    function automatic logic op_has_carry(alu_op_e op);
        case (op)
            op_neg_a, op_neg_b, op_a_inc, op_b_inc, op_a_dec, op_b_dec,
            op_add, op_sub, op_rsub, op_add_c, op_sub_c, op_rsub_c: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- include/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand and result width of the datapath
`define ALU_DATA_W 8

// opcode width for four columns of eight operations
`define ALU_OP_W 5

// operand register file size and its address width
`define ALU_REG_COUNT 4
`define ALU_REG_AW 2

`endif
